// File: source/alu_pkg.sv
package alu_pkg;

        localparam int data_w  = 32;
        localparam int shamt_w = 5;

        // encoded 0 to f in this order.
        typedef enum logic [3:0] {
                op_sll,
                op_srl,
                op_sra,
                op_add,
                op_sub,
                op_and,
                op_or,
                op_xor,
                op_nor,
                op_slt,
                op_beq,
                op_bne,
                op_lui,
                op_mul,
                op_div,
                op_mov
        } alu_op_e;

        typedef struct packed {
                alu_op_e              op;
                logic [data_w-1:0]    s;
                logic [data_w-1:0]    t;
                logic [shamt_w-1:0]   shamt;
        } alu_cmd_t;

        typedef struct packed {
                logic [data_w-1:0]    out;
                logic                 zero;
                logic                 overflow;
        } alu_res_t;

        typedef enum logic [1:0] {
                div_idle,
                div_run,
                div_done
        } div_state_e;

endpackage

// File: source/cmd_intake.sv
`timescale 1ns/10ps

module cmd_intake import alu_pkg::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     cmd_req,
        input  alu_cmd_t cmd,
        output logic     cmd_ack,
        output logic     issue_valid,
        output alu_cmd_t issue_cmd,
        input  logic     issue_take
);

        logic     slot_full;
        alu_cmd_t slot_cmd;
        logic     slot_load;

        // a fresh request only, and only into an empty slot.
        assign slot_load = cmd_req && !cmd_ack && !slot_full;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        cmd_ack   <= 1'b0;
                        slot_full <= 1'b0;
                end else begin
                        if (slot_load) begin
                                cmd_ack <= 1'b1;
                        end else if (!cmd_req) begin
                                cmd_ack <= 1'b0; // phase four.
                        end

                        if (slot_load) begin
                                slot_full <= 1'b1;
                        end else if (issue_take) begin
                                slot_full <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (slot_load) begin
                        slot_cmd <= cmd;
                end
        end

        assign issue_valid = slot_full;
        assign issue_cmd   = slot_cmd;

        // req may drop only once it has been acked.
        req_held_to_ack: assert property (
                @(posedge clk) disable iff (!arst_n)
                $fell(cmd_req) |-> cmd_ack
        );

        take_needs_valid: assert property (
                @(posedge clk) disable iff (!arst_n)
                issue_take |-> issue_valid
        );

endmodule

// File: source/alu_core.sv
`timescale 1ns/10ps

module alu_core import alu_pkg::*; (
        input  alu_cmd_t cmd,
        output alu_res_t res
);

        logic [data_w-1:0]          sum;
        logic [data_w-1:0]          diff;
        logic signed [2*data_w-1:0] prod;
        logic                       s_msb;
        logic                       t_msb;

        assign sum   = cmd.s + cmd.t;
        assign diff  = cmd.s - cmd.t;
        assign prod  = $signed(cmd.s) * $signed(cmd.t); // full 64-bit product.
        assign s_msb = cmd.s[data_w-1];
        assign t_msb = cmd.t[data_w-1];

        always_comb begin
                res = '0;
                case (cmd.op)
                op_sll: res.out = cmd.s << cmd.shamt;
                op_srl: res.out = cmd.s >> cmd.shamt;
                op_sra: res.out = $signed(cmd.s) >>> cmd.shamt;
                op_add: begin
                        res.out      = sum;
                        res.overflow = (s_msb == t_msb) && (sum[data_w-1] != s_msb);
                end
                op_sub: begin
                        res.out      = diff;
                        res.overflow = (s_msb != t_msb) && (diff[data_w-1] != s_msb);
                end
                op_and: res.out = cmd.s & cmd.t;
                op_or:  res.out = cmd.s | cmd.t;
                op_xor: res.out = cmd.s ^ cmd.t;
                op_nor: res.out = ~(cmd.s | cmd.t);
                op_slt: begin
                        res.out = {{(data_w-1){1'b0}}, $signed(cmd.s) < $signed(cmd.t)};
                end
                op_beq: res.zero = (cmd.s == cmd.t); // out stays 0.
                op_bne: res.zero = (cmd.s != cmd.t);
                op_lui: begin
                        res.out = {cmd.t[data_w/2-1:0], {(data_w/2){1'b0}}};
                end
                op_mul: begin
                        res.out      = prod[data_w-1:0];
                        res.overflow = prod[2*data_w-1:data_w] != {data_w{prod[data_w-1]}};
                end
                op_div: begin
                        res = '0; // divider owns this one.
                end
                op_mov: res.out = cmd.t;
                endcase
        end

endmodule

// File: source/alu_divider.sv
`timescale 1ns/10ps

module alu_divider import alu_pkg::*; #(
        parameter int div_bits = 1
) (
        input  logic              clk,
        input  logic              arst_n,
        input  logic              start,
        input  logic [data_w-1:0] dividend,
        input  logic [data_w-1:0] divisor,
        output logic              busy,
        output logic              done,
        output alu_res_t          res
);

        localparam int steps = data_w / div_bits;
        localparam int cnt_w = $clog2(steps + 1);

        div_state_e        state;
        logic [cnt_w-1:0]  cnt;
        logic [data_w-1:0] dvsr_q;
        logic [data_w-1:0] rem_q;
        logic [data_w-1:0] quo_q;
        logic              ovf_q;
        logic [data_w-1:0] rem_nx;
        logic [data_w-1:0] quo_nx;
        logic              div_zero;
        logic              launch;

        assign div_zero = (divisor == '0);
        assign launch   = start && (state == div_idle);

        // div_bits restoring steps per clock.
        always_comb begin
                logic [data_w:0] partial;
                logic [data_w:0] trial;
                rem_nx = rem_q;
                quo_nx = quo_q;
                for (int i = 0; i < div_bits; i++) begin
                        partial = {rem_nx, quo_nx[data_w-1]};
                        trial   = partial - {1'b0, dvsr_q};
                        if (!trial[data_w]) begin
                                rem_nx = trial[data_w-1:0];
                        end else begin
                                rem_nx = partial[data_w-1:0];
                        end
                        quo_nx = {quo_nx[data_w-2:0], !trial[data_w]};
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= div_idle;
                        cnt   <= '0;
                end else begin
                        case (state)
                        div_idle: begin
                                if (launch) begin
                                        state <= div_zero ? div_done : div_run;
                                        cnt   <= cnt_w'(steps - 1);
                                end
                        end
                        div_run: begin
                                cnt <= cnt - cnt_w'(1);
                                if (cnt == '0) begin
                                        state <= div_done;
                                end
                        end
                        div_done: state <= div_idle; // single done cycle.
                        default:  state <= div_idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (launch) begin
                        dvsr_q <= divisor;
                        rem_q  <= '0;
                        quo_q  <= div_zero ? '0 : dividend;
                        ovf_q  <= div_zero;
                end else if (state == div_run) begin
                        rem_q <= rem_nx;
                        quo_q <= quo_nx;
                end
        end

        assign busy = (state != div_idle);
        assign done = (state == div_done);
        assign res  = '{out: quo_q, zero: 1'b0, overflow: ovf_q};

        no_start_when_busy: assert property (
                @(posedge clk) disable iff (!arst_n)
                start |-> !busy
        );

endmodule

// File: source/result_sender.sv
`timescale 1ns/10ps

module result_sender import alu_pkg::*; (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     load,
        input  alu_res_t load_res,
        output logic     full,
        output logic     res_req,
        output alu_res_t res,
        input  logic     res_ack
);

        alu_res_t res_q;

        // full without req means waiting for ack to drop.
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        full    <= 1'b0;
                        res_req <= 1'b0;
                end else if (load) begin
                        full    <= 1'b1;
                        res_req <= 1'b1;
                end else if (res_req && res_ack) begin
                        res_req <= 1'b0;
                end else if (full && !res_req && !res_ack) begin
                        full <= 1'b0; // handshake closed.
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        res_q <= load_res;
                end
        end

        assign res = res_q;

        res_held: assert property (
                @(posedge clk) disable iff (!arst_n)
                res_req |=> $stable(res)
        );

        no_load_when_full: assert property (
                @(posedge clk) disable iff (!arst_n)
                load |-> !full
        );

endmodule

// File: source/alu_unit_top.sv
`timescale 1ns/10ps

module alu_unit_top import alu_pkg::*; #(
        parameter int div_bits = 1
) (
        input  logic     clk,
        input  logic     arst_n,
        input  logic     cmd_req,
        input  alu_cmd_t cmd,
        output logic     cmd_ack,
        output logic     res_req,
        output alu_res_t res,
        input  logic     res_ack
);

        logic     issue_valid;
        alu_cmd_t issue_cmd;
        logic     issue_take;
        logic     is_div;
        logic     div_busy;
        logic     div_done;
        logic     full;
        logic     sender_load;
        alu_res_t core_res;
        alu_res_t div_res;
        alu_res_t load_res;

        cmd_intake u_intake (
                .clk         (clk),
                .arst_n      (arst_n),
                .cmd_req     (cmd_req),
                .cmd         (cmd),
                .cmd_ack     (cmd_ack),
                .issue_valid (issue_valid),
                .issue_cmd   (issue_cmd),
                .issue_take  (issue_take)
        );

        alu_core u_core (
                .cmd (issue_cmd),
                .res (core_res)
        );

        // divider busy covers its done cycle too.
        assign issue_take  = issue_valid && !div_busy && !full;
        assign is_div      = (issue_cmd.op == op_div);
        assign sender_load = (issue_take && !is_div) || div_done;
        assign load_res    = div_done ? div_res : core_res;

        alu_divider #(
                .div_bits (div_bits)
        ) u_divider (
                .clk      (clk),
                .arst_n   (arst_n),
                .start    (issue_take && is_div),
                .dividend (issue_cmd.s),
                .divisor  (issue_cmd.t),
                .busy     (div_busy),
                .done     (div_done),
                .res      (div_res)
        );

        result_sender u_sender (
                .clk      (clk),
                .arst_n   (arst_n),
                .load     (sender_load),
                .load_res (load_res),
                .full     (full),
                .res_req  (res_req),
                .res      (res),
                .res_ack  (res_ack)
        );

endmodule

// File: test/alu_unit_tb.sv
`timescale 1ns/10ps

module alu_unit_tb import alu_pkg::*; ();

        logic     clk;
        logic     arst_n;
        logic     cmd_req;
        alu_cmd_t cmd;
        logic     cmd_ack;
        logic     res_req;
        alu_res_t res;
        logic     res_ack;

        alu_cmd_t cmds[$];
        int       line_nos[$];
        alu_res_t exp_q[$];
        int       cycles      = 0;
        int       cycle_limit = 0;

        alu_unit_top #(
                .div_bits (2)
        ) dut_i (
                .clk     (clk),
                .arst_n  (arst_n),
                .cmd_req (cmd_req),
                .cmd     (cmd),
                .cmd_ack (cmd_ack),
                .res_req (res_req),
                .res     (res),
                .res_ack (res_ack)
        );

        always #50 clk = ~clk;

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles > cycle_limit) begin
                        $display("** Error: timeout after %0d cycles, a handshake never finished",
                                 cycles);
                        stop_run();
                end
        end

        task stop_run;
                $display("FAIL: see errors above");
                $fatal(1, "run stopped at first error");
        endtask

        task check_res(input string name, input alu_res_t exp, input alu_res_t act);
                string exp_txt;
                string act_txt;
                if (act !== exp) begin
                        exp_txt = $sformatf("out=%h zero=%b overflow=%b",
                                            exp.out, exp.zero, exp.overflow);
                        act_txt = $sformatf("out=%h zero=%b overflow=%b",
                                            act.out, act.zero, act.overflow);
                        $display("** Error: %s: expected %s, actual %s",
                                 name, exp_txt, act_txt);
                        stop_run();
                end
        endtask

        // hex columns: op s t shamt out zero overflow.
        task load_patterns;
                int          fd;
                int          n;
                int          line_no;
                string       line;
                logic [3:0]  f_op;
                logic [31:0] f_s;
                logic [31:0] f_t;
                logic [4:0]  f_sh;
                logic [31:0] f_out;
                logic        f_z;
                logic        f_ov;
                alu_cmd_t    c;
                alu_res_t    r;
                fd = $fopen("test/alu_patterns.txt", "r");
                if (fd == 0) begin
                        $display("** Error: cannot open test/alu_patterns.txt");
                        stop_run();
                end else begin
                        line_no = 0;
                        while (!$feof(fd)) begin
                                if ($fgets(line, fd) == 0) break;
                                line_no = line_no + 1;
                                n = $sscanf(line, "%h %h %h %h %h %h %h",
                                            f_op, f_s, f_t, f_sh, f_out, f_z, f_ov);
                                if (n == 7) begin
                                        c.op    = alu_op_e'(f_op);
                                        c.s     = f_s;
                                        c.t     = f_t;
                                        c.shamt = f_sh;
                                        r.out      = f_out;
                                        r.zero     = f_z;
                                        r.overflow = f_ov;
                                        cmds.push_back(c);
                                        line_nos.push_back(line_no);
                                        exp_q.push_back(r); // file order is result order.
                                end else if (n > 0) begin
                                        $display("** Error: pattern line %0d is malformed",
                                                 line_no);
                                        stop_run();
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task send_cmd(input alu_cmd_t c);
                cmd     = c;
                cmd_req = 1'b1;
                @(negedge clk);
                while (!cmd_ack) @(negedge clk); // slot may be busy.
                cmd_req = 1'b0;
                @(negedge clk);
                while (cmd_ack) @(negedge clk);
        endtask

        task take_res(input int idx);
                alu_res_t exp;
                alu_op_e  op_v;
                int       gap;
                string    name;
                while (!res_req) @(negedge clk);
                gap = int'($urandom % 4);
                repeat (gap) @(negedge clk);
                exp  = exp_q.pop_front();
                op_v = cmds[idx].op;
                name = $sformatf("%s line %0d", op_v.name(), line_nos[idx]);
                check_res(name, exp, res);
                res_ack = 1'b1;
                @(negedge clk);
                while (res_req) @(negedge clk);
                res_ack = 1'b0;
        endtask

        initial begin
                void'($urandom(75229));
                clk     = 1'b0;
                arst_n  = 1'b0;
                cmd_req = 1'b0;
                cmd     = '0;
                res_ack = 1'b0;
                load_patterns();
                cycle_limit = cmds.size() * 60 + 100;
                repeat (3) @(negedge clk);
                arst_n = 1'b1;
                @(negedge clk);
                fork
                        begin
                                foreach (cmds[i]) send_cmd(cmds[i]);
                        end
                        begin
                                for (int i = 0; i < cmds.size(); i++) take_res(i);
                        end
                join
                repeat (10) @(negedge clk); // a late extra result would show here.
                if (exp_q.size() == 0 && !res_req) begin
                        $display("PASS: all tests");
                        $finish;
                end else begin
                        $display("** Error: unexpected extra result or %0d results missing",
                                 exp_q.size());
                        stop_run();
                end
        end

endmodule

// File: test/alu_patterns.txt
# hex columns: opcode s t shamt expected_out expected_zero expected_overflow
# opcodes: 0 sll 1 srl 2 sra 3 add 4 sub 5 and 6 or 7 xor 8 nor 9 slt a beq b bne c lui d mul e div f mov
0 00000001 00000000 04 00000010 0 0
1 80000000 00000000 1f 00000001 0 0
2 f0000000 00000000 04 ff000000 0 0
2 80000010 00000000 04 f8000001 0 0
5 ff00ff00 0f0f0f0f 00 0f000f00 0 0
6 ff00ff00 0f0f0f0f 00 ff0fff0f 0 0
7 ff00ff00 0f0f0f0f 00 f00ff00f 0 0
8 ff00ff00 0f0f0f0f 00 00f000f0 0 0
3 00000005 00000007 00 0000000c 0 0
3 7fffffff 00000001 00 80000000 0 1
3 80000000 80000000 00 00000000 0 1
3 ffffffff 00000001 00 00000000 0 0
4 0000000a 00000003 00 00000007 0 0
4 80000000 00000001 00 7fffffff 0 1
4 7fffffff ffffffff 00 80000000 0 1
9 ffffffff 00000001 00 00000001 0 0
9 00000001 ffffffff 00 00000000 0 0
a 12345678 12345678 00 00000000 1 0
a 00000001 00000002 00 00000000 0 0
b 00000001 00000002 00 00000000 1 0
b 00000005 00000005 00 00000000 0 0
c ffffffff abcd1234 00 12340000 0 0
f 11111111 deadbeef 00 deadbeef 0 0
d 00000006 00000007 00 0000002a 0 0
d fffffffe 00000003 00 fffffffa 0 0
d 00010000 00010000 00 00000000 0 1
d 80000000 00000002 00 00000000 0 1
d 40000000 00000002 00 80000000 0 1
e 00000064 00000007 00 0000000e 0 0
3 00000001 00000001 00 00000002 0 0
e ffffffff 00000010 00 0fffffff 0 0
f 00000000 00000042 00 00000042 0 0
e 12345678 00000000 00 00000000 0 1
0 00000003 00000000 01 00000006 0 0
e 80000000 00000003 00 2aaaaaaa 0 0
5 0000ffff 00ff00ff 00 000000ff 0 0
e 00000003 00000009 00 00000000 0 0

// File: tb.f
source/alu_pkg.sv
source/cmd_intake.sv
source/alu_core.sv
source/alu_divider.sv
source/result_sender.sv
source/alu_unit_top.sv
test/alu_unit_tb.sv

// File: Makefile
TOP := alu_unit_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
